// File: src/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// bus widths, word addressed
`define SOC_ADDR_W 30
`define SOC_DATA_W 32
`define SOC_SEL_W 4

// memory depth in words, as an index width
`define SOC_RAM_AW 10

// region select bits of the word address
`define SOC_REGION_HI 29
`define SOC_REGION_LO 21

// region numbers
`define SOC_REGION_MEM 0
`define SOC_REGION_IO 1

// value returned by the ID register
`define SOC_ID_WORD 32'h20191028

`endif

// File: src/bus_pkg.sv
`include "soc_defs.svh"

package bus_pkg;

    // request from a master, also used on the merged bus and slave ports
    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`SOC_ADDR_W-1:0]    adr;
        logic [`SOC_DATA_W-1:0]    dat;
        logic [`SOC_SEL_W-1:0]     sel;
    } wb_req_t;

    // response back toward a master
    typedef struct packed {
        logic                      ack;
        logic                      err;
        logic                      stall;
        logic [`SOC_DATA_W-1:0]    dat;
    } wb_rsp_t;

endpackage : bus_pkg

// File: src/map_pkg.sv
package map_pkg;

    // one-hot target of the current request
    typedef struct packed {
        logic mem;
        logic io;
        logic none;
    } dev_sel_t;

    // register offsets inside the io block, word address bits 3..0
    typedef enum logic [3:0] {
        IO_ID       = 4'h0,
        IO_SCRATCH  = 4'h1,
        IO_ERR_ADDR = 4'h2,
        IO_POWER    = 4'h3,
        IO_IRQ      = 4'h4,
        IO_SWITCHES = 4'h5,
        IO_LEDS     = 4'h6
    } io_reg_e;

endpackage : map_pkg

// File: src/bus_priority_arbiter.sv
`timescale 1ns/1ns

module bus_priority_arbiter (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  bus_pkg::wb_req_t  i_a_req,
    input  bus_pkg::wb_req_t  i_b_req,
    output bus_pkg::wb_rsp_t  o_a_rsp,
    output bus_pkg::wb_rsp_t  o_b_rsp,
    output bus_pkg::wb_req_t  o_req,
    input  bus_pkg::wb_rsp_t  i_rsp
);

    logic r_a_owner;
    logic a_own;

    // A wins outright whenever B is not in a cycle
    assign a_own = r_a_owner || !i_b_req.cyc;

    // B only grabs the bus while A is idle, then holds it until its cyc drops
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_a_owner <= 1'b1;
        end else if (!i_b_req.cyc) begin
            r_a_owner <= 1'b1;
        end else if (i_b_req.stb && !i_a_req.cyc) begin
            r_a_owner <= 1'b0;
        end
    end

    // owner's request goes straight through
    assign o_req = a_own ? i_a_req : i_b_req;

    // responses steered to the owner only, loser is held off with stall
    always_comb begin
        o_a_rsp = '0;
        o_b_rsp = '0;
        if (a_own) begin
            o_a_rsp.ack   = i_rsp.ack;
            o_a_rsp.err   = i_rsp.err;
            o_a_rsp.stall = i_rsp.stall;
            o_a_rsp.dat   = i_rsp.dat;
            o_b_rsp.stall = i_b_req.stb;
        end else begin
            o_b_rsp.ack   = i_rsp.ack;
            o_b_rsp.err   = i_rsp.err;
            o_b_rsp.stall = i_rsp.stall;
            o_b_rsp.dat   = i_rsp.dat;
            o_a_rsp.stall = i_a_req.stb;
        end
    end

endmodule : bus_priority_arbiter

// File: src/wb_ram.sv
`timescale 1ns/1ns
`include "soc_defs.svh"

module wb_ram #(
    parameter int RAM_AW = `SOC_RAM_AW
) (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  bus_pkg::wb_req_t  i_req,
    output bus_pkg::wb_rsp_t  o_rsp
);

    logic [`SOC_DATA_W-1:0] mem [2**RAM_AW];
    logic [RAM_AW-1:0]      idx;
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   ack;
    logic                   hit;

    assign idx = i_req.adr[RAM_AW-1:0];
    assign hit = i_req.cyc && i_req.stb;

    // byte-lane writes, read data always one cycle behind the address
    always_ff @(posedge i_clk) begin
        if (hit && i_req.we) begin
            for (int b = 0; b < `SOC_SEL_W; b++) begin
                if (i_req.sel[b]) begin
                    mem[idx][8*b +: 8] <= i_req.dat[8*b +: 8];
                end
            end
        end
        rdata <= mem[idx];
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= hit;
        end
    end

    // never stalls, never errors
    assign o_rsp.ack   = ack;
    assign o_rsp.err   = 1'b0;
    assign o_rsp.stall = 1'b0;
    assign o_rsp.dat   = rdata;

endmodule : wb_ram

// File: src/io_regs.sv
`timescale 1ns/1ns
`include "soc_defs.svh"

module io_regs (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  bus_pkg::wb_req_t  i_req,
    output bus_pkg::wb_rsp_t  o_rsp,
    input  logic              i_err_pulse,
    input  logic [15:0]       i_switches,
    output logic [15:0]       o_leds,
    output logic              o_irq
);

    map_pkg::io_reg_e        offs;
    logic                    hit;
    logic                    wr;
    logic                    ack;
    logic [`SOC_DATA_W-1:0]  rdata;
    logic [`SOC_DATA_W-1:0]  scratch;
    logic [`SOC_ADDR_W-1:0]  err_addr;
    logic [31:0]             power_cnt;
    logic                    irq;
    logic [15:0]             leds;

    assign offs = map_pkg::io_reg_e'(i_req.adr[3:0]);
    assign hit  = i_req.cyc && i_req.stb;
    assign wr   = hit && i_req.we;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ack      <= 1'b0;
            scratch  <= '0;
            irq      <= 1'b0;
            leds     <= '0;
            err_addr <= '0;
        end else begin
            ack <= hit;
            if (wr && offs == map_pkg::IO_SCRATCH) begin
                for (int b = 0; b < `SOC_SEL_W; b++) begin
                    if (i_req.sel[b]) begin
                        scratch[8*b +: 8] <= i_req.dat[8*b +: 8];
                    end
                end
            end
            if (wr && offs == map_pkg::IO_IRQ) begin
                irq <= i_req.dat[0];
            end
            if (wr && offs == map_pkg::IO_LEDS) begin
                leds <= i_req.dat[15:0];
            end
            // the failing request is still on the bus during the pulse
            if (i_err_pulse) begin
                err_addr <= i_req.adr;
            end
        end
    end

    // free-running uptime, top bit sticks once reached
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            power_cnt <= '0;
        end else if (!power_cnt[31]) begin
            power_cnt <= power_cnt + 32'd1;
        end else begin
            power_cnt[30:0] <= power_cnt[30:0] + 31'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        case (offs)
            map_pkg::IO_ID:       rdata <= `SOC_ID_WORD;
            map_pkg::IO_SCRATCH:  rdata <= scratch;
            map_pkg::IO_ERR_ADDR: rdata <= {err_addr, 2'b00};
            map_pkg::IO_POWER:    rdata <= power_cnt;
            map_pkg::IO_IRQ:      rdata <= {31'd0, irq};
            map_pkg::IO_SWITCHES: rdata <= {16'd0, i_switches};
            map_pkg::IO_LEDS:     rdata <= {16'd0, leds};
            default:              rdata <= '0;
        endcase
    end

    assign o_rsp.ack   = ack;
    assign o_rsp.err   = 1'b0;
    assign o_rsp.stall = 1'b0;
    assign o_rsp.dat   = rdata;

    assign o_leds = leds;
    assign o_irq  = irq;

endmodule : io_regs

// File: src/slave_router.sv
`timescale 1ns/1ns
`include "soc_defs.svh"

module slave_router (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  bus_pkg::wb_req_t  i_req,
    output bus_pkg::wb_rsp_t  o_rsp,
    output bus_pkg::wb_req_t  o_mem_req,
    output bus_pkg::wb_req_t  o_io_req,
    input  bus_pkg::wb_rsp_t  i_mem_rsp,
    input  bus_pkg::wb_rsp_t  i_io_rsp,
    output logic              o_err_pulse
);

    localparam int REGION_W = `SOC_REGION_HI - `SOC_REGION_LO + 1;

    map_pkg::dev_sel_t       sel;
    logic [REGION_W-1:0]     region;
    logic                    hit;
    logic                    err_pend;
    logic                    rsp_ack;
    logic                    rsp_err;
    logic [`SOC_DATA_W-1:0]  rsp_dat;

    assign region = i_req.adr[`SOC_REGION_HI:`SOC_REGION_LO];
    assign hit    = i_req.cyc && i_req.stb;

    always_comb begin
        sel.mem  = (region == REGION_W'(`SOC_REGION_MEM));
        sel.io   = (region == REGION_W'(`SOC_REGION_IO));
        sel.none = !sel.mem && !sel.io;
    end

    // same request to both slaves, strobe only to the one addressed
    always_comb begin
        o_mem_req     = i_req;
        o_mem_req.stb = i_req.stb && sel.mem;
        o_io_req      = i_req;
        o_io_req.stb  = i_req.stb && sel.io;
    end

    // io_regs latches the address while this is high
    assign o_err_pulse = hit && sel.none;

    // err goes through one extra stage so it lines up with slave acks
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            err_pend <= 1'b0;
            rsp_ack  <= 1'b0;
            rsp_err  <= 1'b0;
        end else begin
            err_pend <= hit && sel.none;
            rsp_ack  <= i_mem_rsp.ack || i_io_rsp.ack;
            rsp_err  <= err_pend || i_mem_rsp.err || i_io_rsp.err;
        end
    end

    // io wins when both could drive
    always_ff @(posedge i_clk) begin
        if (i_io_rsp.ack) begin
            rsp_dat <= i_io_rsp.dat;
        end else if (i_mem_rsp.ack) begin
            rsp_dat <= i_mem_rsp.dat;
        end else begin
            rsp_dat <= '0;
        end
    end

    assign o_rsp.ack   = rsp_ack;
    assign o_rsp.err   = rsp_err;
    assign o_rsp.stall = (sel.mem && i_mem_rsp.stall) || (sel.io && i_io_rsp.stall);
    assign o_rsp.dat   = rsp_dat;

endmodule : slave_router

// File: src/soc_bus_top.sv
`timescale 1ns/1ns

module soc_bus_top (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  bus_pkg::wb_req_t  i_a_req,
    output bus_pkg::wb_rsp_t  o_a_rsp,
    input  bus_pkg::wb_req_t  i_b_req,
    output bus_pkg::wb_rsp_t  o_b_rsp,
    input  logic [15:0]       i_switches,
    output logic [15:0]       o_leds,
    output logic              o_irq
);

    // merged bus between arbiter and router
    bus_pkg::wb_req_t bus_req;
    bus_pkg::wb_rsp_t bus_rsp;

    // per-slave links
    bus_pkg::wb_req_t mem_req;
    bus_pkg::wb_rsp_t mem_rsp;
    bus_pkg::wb_req_t io_req;
    bus_pkg::wb_rsp_t io_rsp;
    logic             err_pulse;

    bus_priority_arbiter u_arb (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_a_req  (i_a_req),
        .i_b_req  (i_b_req),
        .o_a_rsp  (o_a_rsp),
        .o_b_rsp  (o_b_rsp),
        .o_req    (bus_req),
        .i_rsp    (bus_rsp)
    );

    slave_router u_router (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_req       (bus_req),
        .o_rsp       (bus_rsp),
        .o_mem_req   (mem_req),
        .o_io_req    (io_req),
        .i_mem_rsp   (mem_rsp),
        .i_io_rsp    (io_rsp),
        .o_err_pulse (err_pulse)
    );

    wb_ram u_ram (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_req    (mem_req),
        .o_rsp    (mem_rsp)
    );

    io_regs u_io (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_req       (io_req),
        .o_rsp       (io_rsp),
        .i_err_pulse (err_pulse),
        .i_switches  (i_switches),
        .o_leds      (o_leds),
        .o_irq       (o_irq)
    );

endmodule : soc_bus_top

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic o_clk,
    output logic o_arst_n
);

    // 8 ns period
    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    // reset held over the first ten rising edges
    initial begin
        o_arst_n = 1'b0;
        repeat (10) @(posedge o_clk);
        #1;
        o_arst_n = 1'b1;
    end

endmodule : tb_clock_gen

// File: dv/soc_bus_properties.sv
`timescale 1ns/1ns

module soc_bus_properties (
    input logic             i_clk,
    input logic             i_arst_n,
    input bus_pkg::wb_req_t i_a_req,
    input bus_pkg::wb_req_t i_b_req,
    input bus_pkg::wb_rsp_t i_a_rsp,
    input bus_pkg::wb_rsp_t i_b_rsp
);

    logic a_acc;
    logic b_acc;

    assign a_acc = i_a_req.cyc && i_a_req.stb && !i_a_rsp.stall;
    assign b_acc = i_b_req.cyc && i_b_req.stb && !i_b_rsp.stall;

    a_ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_a_rsp.ack && i_a_rsp.err)) else $error("master A saw ack and err together");
    b_ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_b_rsp.ack && i_b_rsp.err)) else $error("master B saw ack and err together");

    // only the owner ever gets a response
    single_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_a_rsp.ack && i_b_rsp.ack)) else $error("both masters acked in one cycle");

    // fixed two-cycle latency, both directions
    a_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        a_acc |-> ##2 (i_a_rsp.ack || i_a_rsp.err)) else $error("A strobe not answered at +2");
    a_no_stray: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_a_rsp.ack |-> $past(a_acc, 2)) else $error("A ack without strobe two cycles before");
    b_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        b_acc |-> ##2 (i_b_rsp.ack || i_b_rsp.err)) else $error("B strobe not answered at +2");
    b_no_stray: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_b_rsp.ack |-> $past(b_acc, 2)) else $error("B ack without strobe two cycles before");

endmodule : soc_bus_properties

bind soc_bus_top soc_bus_properties u_props (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_a_req  (i_a_req),
    .i_b_req  (i_b_req),
    .i_a_rsp  (o_a_rsp),
    .i_b_rsp  (o_b_rsp)
);

// File: dv/soc_bus_tb.sv
`timescale 1ns/1ns
`include "soc_defs.svh"

module soc_bus_tb;

    localparam logic [1:0]  K_WRITE = 2'd0;
    localparam logic [1:0]  K_READ  = 2'd1;
    localparam logic [1:0]  K_CAPT  = 2'd2;
    localparam logic [1:0]  K_ERR   = 2'd3;
    localparam logic [29:0] IO_BASE = 30'h0020_0000;

    // one outstanding access, kept in issue order
    typedef struct packed {
        logic        on_b;
        logic [1:0]  kind;
        logic [31:0] dat;
        logic [31:0] acc_cyc;
    } exp_entry_t;

    logic             clk;
    logic             arst_n;
    bus_pkg::wb_req_t a_req;
    bus_pkg::wb_req_t b_req;
    bus_pkg::wb_rsp_t a_rsp;
    bus_pkg::wb_rsp_t b_rsp;
    logic [15:0]      switches;
    logic [15:0]      leds;
    logic             irq;

    exp_entry_t       exp_q[$];
    logic [31:0]      got_q[$];
    exp_entry_t       cur;
    bus_pkg::wb_rsp_t rsp;
    logic [31:0]      cycle = '0;
    logic [31:0]      last_acc;
    logic [31:0]      first_acc;
    logic [31:0]      rnd;
    int               seed = 32'h30ed9fc5;
    int               errors = 0;
    int               checks = 0;
    int               tests = 0;
    int               test_err = 0;
    string            test_name = "reset";

    // reference model state
    logic [31:0]      mem_model [2**`SOC_RAM_AW];
    logic [31:0]      scratch_m = '0;
    logic [29:0]      err_addr_m = '0;
    logic             irq_m = 1'b0;
    logic [15:0]      leds_m = '0;
    logic [29:0]      addr_list [8];

    tb_clock_gen u_clk_gen (
        .o_clk    (clk),
        .o_arst_n (arst_n)
    );

    soc_bus_top UUT (
        .i_clk      (clk),
        .i_arst_n   (arst_n),
        .i_a_req    (a_req),
        .o_a_rsp    (a_rsp),
        .i_b_req    (b_req),
        .o_b_rsp    (b_rsp),
        .i_switches (switches),
        .o_leds     (leds),
        .o_irq      (irq)
    );

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    function automatic logic [31:0] expected_read(input logic [29:0] adr);
        if (adr[`SOC_REGION_HI:`SOC_REGION_LO] == 9'(`SOC_REGION_MEM)) begin
            return mem_model[adr[`SOC_RAM_AW-1:0]];
        end
        if (adr[`SOC_REGION_HI:`SOC_REGION_LO] != 9'(`SOC_REGION_IO)) begin
            return 32'd0;
        end
        // power counter reads are captured, not predicted
        case (adr[3:0])
            4'h0:    return `SOC_ID_WORD;
            4'h1:    return scratch_m;
            4'h2:    return {err_addr_m, 2'b00};
            4'h4:    return {31'd0, irq_m};
            4'h5:    return {16'd0, switches};
            4'h6:    return {16'd0, leds_m};
            default: return 32'd0;
        endcase
    endfunction

    task automatic model_write(input logic [29:0] adr, input logic [31:0] dat);
        if (adr[`SOC_REGION_HI:`SOC_REGION_LO] == 9'(`SOC_REGION_MEM)) begin
            mem_model[adr[`SOC_RAM_AW-1:0]] = dat;
        end else if (adr[`SOC_REGION_HI:`SOC_REGION_LO] == 9'(`SOC_REGION_IO)) begin
            case (adr[3:0])
                4'h1:    scratch_m = dat;
                4'h4:    irq_m = dat[0];
                4'h6:    leds_m = dat[15:0];
                default: ;
            endcase
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s in test %s", what, test_name);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic set_req(input logic on_b, input bus_pkg::wb_req_t r);
        if (on_b) begin
            b_req = r;
        end else begin
            a_req = r;
        end
    endtask

    // called at posedge+1, returns at posedge+1 with stb low and cyc held
    task automatic issue(input logic on_b, input logic we, input logic [29:0] adr,
                         input logic [31:0] dat, input logic [1:0] kind);
        bus_pkg::wb_req_t req;
        exp_entry_t       e;
        int               tries;
        req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: 4'hf};
        set_req(on_b, req);
        tries = 0;
        @(negedge clk);
        while ((on_b ? b_rsp.stall : a_rsp.stall) && tries < 50) begin
            tries++;
            @(negedge clk);
        end
        if (on_b ? b_rsp.stall : a_rsp.stall) begin
            timeout_fail("a stalled request to be accepted");
        end
        e.on_b    = on_b;
        e.kind    = kind;
        e.dat     = (kind == K_READ) ? expected_read(adr) : dat;
        e.acc_cyc = cycle;
        exp_q.push_back(e);
        last_acc = cycle;
        if (we) begin
            model_write(adr, dat);
        end
        if (kind == K_ERR) begin
            err_addr_m = adr;
        end
        @(posedge clk);
        #1;
        req.stb = 1'b0;
        set_req(on_b, req);
    endtask

    // drain outstanding responses, then release the bus
    task automatic end_cycle(input logic on_b);
        int tries;
        tries = 0;
        while (exp_q.size() != 0 && tries < 20) begin
            @(posedge clk);
            #1;
            tries++;
        end
        if (exp_q.size() != 0) begin
            timeout_fail("outstanding responses");
        end
        set_req(on_b, '0);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err  = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("%s: %s, %0d errors", test_name, (errors == test_err) ? "ok" : "failed",
                 errors - test_err);
    endtask

    // comparator, sampled mid-cycle where responses are settled
    always @(negedge clk) begin
        if (a_rsp.ack || a_rsp.err || b_rsp.ack || b_rsp.err) begin
            rsp = (b_rsp.ack || b_rsp.err) ? b_rsp : a_rsp;
            checks++;
            if (exp_q.size() == 0) begin
                $display("Response in test %s with no access outstanding", test_name);
                errors++;
            end else begin
                cur = exp_q.pop_front();
                assert (cycle == cur.acc_cyc + 32'd2) else begin
                    $display("Fail %s latency: expected cycle %0d actual cycle %0d",
                             test_name, cur.acc_cyc + 32'd2, cycle);
                    errors++;
                end
                assert (cur.on_b == (b_rsp.ack || b_rsp.err)) else begin
                    $display("Response in test %s reached the wrong master", test_name);
                    errors++;
                end
                assert ((cur.kind == K_ERR) ? (rsp.err && !rsp.ack) : (rsp.ack && !rsp.err))
                else begin
                    $display("Fail %s response: expected %s actual ack=%b err=%b", test_name,
                             (cur.kind == K_ERR) ? "err" : "ack", rsp.ack, rsp.err);
                    errors++;
                end
                if (cur.kind == K_READ) begin
                    assert (rsp.dat == cur.dat) else begin
                        $display("Fail %s: expected %h actual %h", test_name, cur.dat, rsp.dat);
                        errors++;
                    end
                end
                if (cur.kind == K_CAPT) begin
                    got_q.push_back(rsp.dat);
                end
            end
        end
    end

    initial begin : run_tests
        int tries;
        a_req    = '0;
        b_req    = '0;
        switches = '0;
        tries    = 0;
        while (!arst_n && tries < 100) begin
            @(posedge clk);
            tries++;
        end
        if (!arst_n) begin
            timeout_fail("reset release");
        end
        @(posedge clk);
        #1;

        start_test("mem_round_trip");
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            addr_list[i] = {20'd0, rnd[9:0]};
            issue(1'b0, 1'b1, addr_list[i], $random(seed), K_WRITE);
        end
        for (int i = 0; i < 8; i++) begin
            issue(1'b0, 1'b0, addr_list[i], 32'd0, K_READ);
        end
        end_cycle(1'b0);
        end_test();

        // eight strobes, one per cycle
        start_test("pipeline");
        for (int i = 0; i < 4; i++) begin
            issue(1'b0, 1'b1, addr_list[i], $random(seed), K_WRITE);
            if (i == 0) begin
                first_acc = last_acc;
            end
            issue(1'b0, 1'b0, addr_list[i], 32'd0, K_READ);
        end
        assert (last_acc - first_acc == 32'd7) else begin
            $display("Fail %s accept span: expected 7 actual %0d", test_name,
                     last_acc - first_acc);
            errors++;
        end
        end_cycle(1'b0);
        end_test();

        start_test("io_regs");
        rnd = $random(seed);
        switches = rnd[31:16];
        issue(1'b0, 1'b0, IO_BASE | 30'h0, 32'd0, K_READ);
        issue(1'b0, 1'b1, IO_BASE | 30'h1, rnd, K_WRITE);
        issue(1'b0, 1'b0, IO_BASE | 30'h1, 32'd0, K_READ);
        issue(1'b0, 1'b1, IO_BASE | 30'h6, rnd, K_WRITE);
        issue(1'b0, 1'b0, IO_BASE | 30'h6, 32'd0, K_READ);
        issue(1'b0, 1'b1, IO_BASE | 30'h4, 32'd1, K_WRITE);
        issue(1'b0, 1'b0, IO_BASE | 30'h5, 32'd0, K_READ);
        end_cycle(1'b0);
        assert (leds == leds_m) else begin
            $display("Fail %s o_leds: expected %h actual %h", test_name, leds_m, leds);
            errors++;
        end
        assert (irq == 1'b1) else begin
            $display("Fail %s o_irq: expected 1 actual %b", test_name, irq);
            errors++;
        end
        end_test();

        // region 2 is unmapped
        start_test("bus_error");
        rnd = $random(seed);
        issue(1'b0, 1'b0, {9'd2, rnd[20:0]}, 32'd0, K_ERR);
        issue(1'b0, 1'b0, IO_BASE | 30'h2, 32'd0, K_READ);
        end_cycle(1'b0);
        end_test();

        start_test("arbitration");
        set_req(1'b1, '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr_list[5], dat: 32'd0,
                        sel: 4'hf});
        issue(1'b0, 1'b1, addr_list[5], $random(seed), K_WRITE);
        issue(1'b0, 1'b0, addr_list[5], 32'd0, K_READ);
        @(negedge clk);
        assert (b_rsp.stall) else begin
            $display("Master B was not stalled while master A owned the bus");
            errors++;
        end
        @(posedge clk);
        #1;
        end_cycle(1'b0);
        issue(1'b1, 1'b0, addr_list[5], 32'd0, K_READ);
        end_cycle(1'b1);
        end_test();

        start_test("power_cnt");
        got_q.delete();
        issue(1'b0, 1'b0, IO_BASE | 30'h3, 32'd0, K_CAPT);
        first_acc = last_acc;
        repeat (6) @(posedge clk);
        #1;
        issue(1'b0, 1'b0, IO_BASE | 30'h3, 32'd0, K_CAPT);
        end_cycle(1'b0);
        if (got_q.size() != 2) begin
            $display("Power counter reads returned %0d values instead of two", got_q.size());
            errors++;
        end else begin
            assert (got_q[1] - got_q[0] == last_acc - first_acc) else begin
                $display("Fail %s delta: expected %0d actual %0d", test_name,
                         last_acc - first_acc, got_q[1] - got_q[0]);
                errors++;
            end
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : soc_bus_tb

// File: list.f
+incdir+src
src/bus_pkg.sv
src/map_pkg.sv
src/bus_priority_arbiter.sv
src/wb_ram.sv
src/io_regs.sv
src/slave_router.sv
src/soc_bus_top.sv
dv/tb_clock_gen.sv
dv/soc_bus_properties.sv
dv/soc_bus_tb.sv

// File: Makefile
TOP = soc_bus_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing --assert -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
